// File: verilog/ex_pkg.sv
package ex_pkg;

    typedef logic [31:0] bus32_t;
    typedef logic [63:0] bus64_t;

    // architectural register index width
    localparam int unsigned REG_ADDR_W = 5;

    // one quotient bit per step
    localparam int unsigned DIV_STEPS = 32;

    // sequential instruction stride
    localparam bus32_t PC_STEP = 32'd4;

    typedef enum logic [7:0] {
        ALU_ADD       = 8'h00,
        ALU_SUB       = 8'h01,
        ALU_AND       = 8'h02,
        ALU_OR        = 8'h03,
        ALU_XOR       = 8'h04,
        ALU_NOR       = 8'h05,
        ALU_SLL       = 8'h06,
        ALU_SRL       = 8'h07,
        ALU_SRA       = 8'h08,
        ALU_SLT       = 8'h09,
        ALU_SLTU      = 8'h0a,
        ALU_PCADDU12I = 8'h0b,
        ALU_DIVW      = 8'h10,
        ALU_MODW      = 8'h11,
        ALU_DIVWU     = 8'h12,
        ALU_MODWU     = 8'h13,
        ALU_BEQ       = 8'h20,
        ALU_BNE       = 8'h21,
        ALU_BLT       = 8'h22,
        ALU_BGE       = 8'h23,
        ALU_BLTU      = 8'h24,
        ALU_BGEU      = 8'h25,
        ALU_JIRL      = 8'h26,
        ALU_B         = 8'h27,
        ALU_BL        = 8'h28,
        ALU_LDB       = 8'h30,
        ALU_LDBU      = 8'h31,
        ALU_LDH       = 8'h32,
        ALU_LDHU      = 8'h33,
        ALU_LDW       = 8'h34,
        ALU_STB       = 8'h35,
        ALU_STH       = 8'h36,
        ALU_STW       = 8'h37,
        ALU_RDCNTVLW  = 8'h40,
        ALU_RDCNTVHW  = 8'h41,
        ALU_NOP       = 8'hff
    } aluop_t;

    // which unit feeds write-back
    typedef enum logic [2:0] {
        ALU_SEL_LOGIC       = 3'd0,
        ALU_SEL_SHIFT       = 3'd1,
        ALU_SEL_ARITHMETIC  = 3'd2,
        ALU_SEL_DIV         = 3'd3,
        ALU_SEL_JUMP_BRANCH = 3'd4,
        ALU_SEL_LOAD_STORE  = 3'd5,
        ALU_SEL_COUNTER     = 3'd6,
        ALU_SEL_NONE        = 3'd7
    } alusel_t;

endpackage

// File: verilog/regular_alu.sv
module regular_alu (
    input  ex_pkg::aluop_t aluop_i,
    input  ex_pkg::bus32_t pc_i,
    input  ex_pkg::bus32_t reg1_i,
    input  ex_pkg::bus32_t reg2_i,
    output ex_pkg::bus32_t result_o
);
    import ex_pkg::*;

    logic [4:0] shamt;

    assign shamt = reg2_i[4:0];

    always_comb begin
        case (aluop_i)
            ALU_ADD: begin
                result_o = reg1_i + reg2_i;
            end
            ALU_SUB: begin
                result_o = reg1_i - reg2_i;
            end
            ALU_AND: begin
                result_o = reg1_i & reg2_i;
            end
            ALU_OR: begin
                result_o = reg1_i | reg2_i;
            end
            ALU_XOR: begin
                result_o = reg1_i ^ reg2_i;
            end
            ALU_NOR: begin
                result_o = ~(reg1_i | reg2_i);
            end
            ALU_SLL: begin
                result_o = reg1_i << shamt;
            end
            ALU_SRL: begin
                result_o = reg1_i >> shamt;
            end
            ALU_SRA: begin
                result_o = bus32_t'($signed(reg1_i) >>> shamt);
            end
            ALU_SLT: begin
                result_o = {31'b0, $signed(reg1_i) < $signed(reg2_i)};
            end
            ALU_SLTU: begin
                result_o = {31'b0, reg1_i < reg2_i};
            end
            // upper immediate arrives already shifted
            ALU_PCADDU12I: begin
                result_o = pc_i + reg2_i;
            end
            default: begin
                result_o = 32'b0;
            end
        endcase
    end

endmodule

// File: verilog/div_alu.sv
module div_alu (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           start_i,
    input  logic           signed_i,
    input  ex_pkg::bus32_t dividend_i,
    input  ex_pkg::bus32_t divisor_i,
    output ex_pkg::bus32_t quotient_o,
    output ex_pkg::bus32_t remainder_o,
    output logic           done_o
);
    import ex_pkg::*;

    logic        busy;
    logic        done_q;
    logic [4:0]  step;
    logic        accept;
    bus32_t      dvd_abs;
    bus32_t      dvs_abs;
    bus32_t      dvs_q;
    bus32_t      rem_q;
    bus32_t      quo_q;
    logic        q_neg_q;
    logic        r_neg_q;
    logic [32:0] trial;
    logic [32:0] diff;

    // only take a new operation when idle
    assign accept = start_i && !busy && !done_q;

    assign dvd_abs = (signed_i && dividend_i[31]) ? -dividend_i : dividend_i;
    assign dvs_abs = (signed_i && divisor_i[31]) ? -divisor_i : divisor_i;

    // shift in next dividend bit, then try the subtract
    assign trial = {rem_q, quo_q[31]};
    assign diff  = trial - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy   <= 1'b0;
            done_q <= 1'b0;
            step   <= 5'd0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                step <= 5'd0;
            end else if (busy) begin
                step <= step + 5'd1;
                if (step == 5'(DIV_STEPS - 1)) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rem_q   <= 32'b0;
            quo_q   <= dvd_abs;
            dvs_q   <= dvs_abs;
            q_neg_q <= signed_i && (dividend_i[31] ^ divisor_i[31]);
            r_neg_q <= signed_i && dividend_i[31];
        end else if (busy) begin
            if (!diff[32]) begin
                rem_q <= diff[31:0];
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                rem_q <= trial[31:0];
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end
    end

    // sign fix on the magnitudes
    assign quotient_o  = q_neg_q ? -quo_q : quo_q;
    assign remainder_o = r_neg_q ? -rem_q : rem_q;
    assign done_o      = done_q;

endmodule

// File: verilog/branch_alu.sv
module branch_alu (
    input  ex_pkg::bus32_t pc_i,
    input  ex_pkg::bus32_t inst_i,
    input  ex_pkg::bus32_t reg1_i,
    input  ex_pkg::bus32_t reg2_i,
    input  ex_pkg::aluop_t aluop_i,
    input  logic           pre_taken_i,
    input  ex_pkg::bus32_t pre_target_i,
    output logic           flush_o,
    output ex_pkg::bus32_t target_o,
    output ex_pkg::bus32_t link_o
);
    import ex_pkg::*;

    bus32_t offs16;
    bus32_t offs26;
    bus32_t seq_pc;
    bus32_t jump_target;
    logic   is_branch;
    logic   taken;

    assign offs16 = {{14{inst_i[25]}}, inst_i[25:10], 2'b00};
    // offs[25:16] sits in inst[9:0]
    assign offs26 = {{4{inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};
    assign seq_pc = pc_i + PC_STEP;

    always_comb begin
        is_branch   = 1'b1;
        jump_target = pc_i + offs16;
        case (aluop_i)
            ALU_BEQ:  taken = reg1_i == reg2_i;
            ALU_BNE:  taken = reg1_i != reg2_i;
            ALU_BLT:  taken = $signed(reg1_i) < $signed(reg2_i);
            ALU_BGE:  taken = $signed(reg1_i) >= $signed(reg2_i);
            ALU_BLTU: taken = reg1_i < reg2_i;
            ALU_BGEU: taken = reg1_i >= reg2_i;
            ALU_JIRL: begin
                taken       = 1'b1;
                jump_target = reg1_i + offs16;
            end
            ALU_B, ALU_BL: begin
                taken       = 1'b1;
                jump_target = pc_i + offs26;
            end
            default: begin
                taken     = 1'b0;
                is_branch = 1'b0;
            end
        endcase
    end

    assign target_o = taken ? jump_target : seq_pc;

    // wrong direction, or right direction with a stale target
    assign flush_o = is_branch
        && ((taken != pre_taken_i) || (taken && (pre_target_i != jump_target)));

    assign link_o = (aluop_i == ALU_BL || aluop_i == ALU_JIRL) ? seq_pc : 32'b0;

endmodule

// File: verilog/lsu_agu.sv
module lsu_agu #(
    parameter ex_pkg::bus32_t UNCACHE_PC_LIMIT = 32'h0000_0120
) (
    input  logic           inst_valid_i,
    input  ex_pkg::aluop_t aluop_i,
    input  ex_pkg::bus32_t pc_i,
    input  ex_pkg::bus32_t inst_i,
    input  ex_pkg::bus32_t reg1_i,
    input  ex_pkg::bus32_t reg2_i,
    output ex_pkg::bus32_t addr_o,
    output logic           ale_o,
    output logic           req_o,
    output logic           valid_o,
    output logic           uncache_o,
    output logic           op_o,
    output ex_pkg::bus32_t wdata_o,
    output logic [3:0]     wstrb_o
);
    import ex_pkg::*;

    logic [11:0] si12;
    bus32_t      addr;
    logic        is_load;
    logic        is_store;
    logic        misaligned;
    logic        low_pc;

    assign si12   = inst_i[21:10];
    assign addr   = reg1_i + {{20{si12[11]}}, si12};
    assign addr_o = addr;

    always_comb begin
        is_load    = 1'b0;
        is_store   = 1'b0;
        misaligned = 1'b0;
        wdata_o    = 32'b0;
        wstrb_o    = 4'b0000;
        case (aluop_i)
            ALU_LDB, ALU_LDBU: begin
                is_load = 1'b1;
                wstrb_o = 4'b1111;
            end
            ALU_LDH, ALU_LDHU: begin
                is_load    = 1'b1;
                misaligned = addr[0];
                wstrb_o    = 4'b1111;
            end
            ALU_LDW: begin
                is_load    = 1'b1;
                misaligned = |addr[1:0];
                wstrb_o    = 4'b1111;
            end
            // byte replicated, one lane enabled
            ALU_STB: begin
                is_store = 1'b1;
                wdata_o  = {4{reg2_i[7:0]}};
                wstrb_o  = 4'b0001 << addr[1:0];
            end
            ALU_STH: begin
                is_store   = 1'b1;
                misaligned = addr[0];
                wdata_o    = {2{reg2_i[15:0]}};
                if (!addr[0]) begin
                    wstrb_o = addr[1] ? 4'b1100 : 4'b0011;
                end
            end
            ALU_STW: begin
                is_store   = 1'b1;
                misaligned = |addr[1:0];
                wdata_o    = reg2_i;
                if (addr[1:0] == 2'b00) begin
                    wstrb_o = 4'b1111;
                end
            end
            default: begin
            end
        endcase
    end

    // boot region goes around the cache
    assign low_pc = pc_i < UNCACHE_PC_LIMIT;

    assign ale_o     = inst_valid_i && misaligned;
    assign req_o     = inst_valid_i && (is_load || is_store) && !misaligned;
    assign uncache_o = req_o && low_pc;
    assign valid_o   = req_o && !low_pc;
    assign op_o      = req_o && is_store;

endmodule

// File: verilog/main_ex.sv
module main_ex #(
    parameter ex_pkg::bus32_t UNCACHE_PC_LIMIT = 32'h0000_0120
) (
    input  logic                          clk,
    input  logic                          reset_i,

    input  logic                          inst_valid_i,
    input  ex_pkg::bus32_t                pc_i,
    input  ex_pkg::bus32_t                inst_i,
    input  ex_pkg::aluop_t                aluop_i,
    input  ex_pkg::alusel_t               alusel_i,
    input  ex_pkg::bus32_t                reg1_i,
    input  ex_pkg::bus32_t                reg2_i,
    input  logic                          reg_write_en_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0] reg_write_addr_i,
    input  logic                          pre_taken_i,
    input  ex_pkg::bus32_t                pre_target_i,
    input  ex_pkg::bus64_t                cnt_i,
    input  logic                          dcache_addr_ok_i,

    output logic                          reg_write_en_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] reg_write_addr_o,
    output ex_pkg::bus32_t                reg_write_data_o,
    output ex_pkg::bus32_t                mem_addr_o,
    output logic                          ale_o,
    output logic                          pause_o,
    output logic                          branch_flush_o,
    output ex_pkg::bus32_t                branch_target_o,

    output logic                          dcache_valid_o,
    output logic                          dcache_uncache_o,
    output logic                          dcache_op_o,
    output ex_pkg::bus32_t                dcache_addr_o,
    output ex_pkg::bus32_t                dcache_wdata_o,
    output logic [3:0]                    dcache_wstrb_o
);
    import ex_pkg::*;

    bus32_t     regular_res;
    bus32_t     quotient;
    bus32_t     remainder;
    bus32_t     link_res;
    bus32_t     counter_res;
    bus32_t     div_res;
    logic       is_div;
    logic       is_mod;
    logic       div_signed;
    logic       div_start;
    logic       div_done;
    logic       br_flush;
    logic       lsu_req;
    bus32_t     lsu_wdata;
    logic [3:0] lsu_wstrb;

    regular_alu u_regular_alu (
        .aluop_i  (aluop_i),
        .pc_i     (pc_i),
        .reg1_i   (reg1_i),
        .reg2_i   (reg2_i),
        .result_o (regular_res)
    );

    assign is_mod     = aluop_i == ALU_MODW || aluop_i == ALU_MODWU;
    assign is_div     = is_mod || aluop_i == ALU_DIVW || aluop_i == ALU_DIVWU;
    assign div_signed = aluop_i == ALU_DIVW || aluop_i == ALU_MODW;
    // start drops in the done cycle, which releases the pause
    assign div_start  = inst_valid_i && is_div && !div_done;

    div_alu u_div_alu (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (div_start),
        .signed_i    (div_signed),
        .dividend_i  (reg1_i),
        .divisor_i   (reg2_i),
        .quotient_o  (quotient),
        .remainder_o (remainder),
        .done_o      (div_done)
    );

    assign div_res = !div_done ? 32'b0 : (is_mod ? remainder : quotient);

    branch_alu u_branch_alu (
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .aluop_i      (aluop_i),
        .pre_taken_i  (pre_taken_i),
        .pre_target_i (pre_target_i),
        .flush_o      (br_flush),
        .target_o     (branch_target_o),
        .link_o       (link_res)
    );

    assign branch_flush_o = inst_valid_i && br_flush;

    lsu_agu #(
        .UNCACHE_PC_LIMIT (UNCACHE_PC_LIMIT)
    ) u_lsu_agu (
        .inst_valid_i (inst_valid_i),
        .aluop_i      (aluop_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .addr_o       (mem_addr_o),
        .ale_o        (ale_o),
        .req_o        (lsu_req),
        .valid_o      (dcache_valid_o),
        .uncache_o    (dcache_uncache_o),
        .op_o         (dcache_op_o),
        .wdata_o      (lsu_wdata),
        .wstrb_o      (lsu_wstrb)
    );

    // quiet bus when nothing is requested
    assign dcache_addr_o  = lsu_req ? mem_addr_o : 32'b0;
    assign dcache_wdata_o = lsu_req ? lsu_wdata : 32'b0;
    assign dcache_wstrb_o = lsu_req ? lsu_wstrb : 4'b0000;

    assign counter_res = (aluop_i == ALU_RDCNTVHW) ? cnt_i[63:32] :
                         (aluop_i == ALU_RDCNTVLW) ? cnt_i[31:0] : 32'b0;

    assign reg_write_en_o   = inst_valid_i && reg_write_en_i;
    assign reg_write_addr_o = reg_write_addr_i;

    always_comb begin
        case (alusel_i)
            ALU_SEL_LOGIC, ALU_SEL_SHIFT, ALU_SEL_ARITHMETIC: reg_write_data_o = regular_res;
            ALU_SEL_DIV:         reg_write_data_o = div_res;
            ALU_SEL_JUMP_BRANCH: reg_write_data_o = link_res;
            ALU_SEL_COUNTER:     reg_write_data_o = counter_res;
            ALU_SEL_LOAD_STORE, ALU_SEL_NONE: reg_write_data_o = 32'b0;
            default:             reg_write_data_o = 32'b0;
        endcase
    end

    // divide pending, or cached request not yet taken
    assign pause_o = div_start || (dcache_valid_o && !dcache_addr_ok_i);

endmodule

// File: tb/ex_model.svh
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// expected single-cycle result for the regular ops
function automatic bus32_t alu_result(aluop_t op, bus32_t pc, bus32_t a, bus32_t b);
    case (op)
        ALU_ADD:       return a + b;
        ALU_SUB:       return a - b;
        ALU_AND:       return a & b;
        ALU_OR:        return a | b;
        ALU_XOR:       return a ^ b;
        ALU_NOR:       return ~(a | b);
        ALU_SLL:       return a << b[4:0];
        ALU_SRL:       return a >> b[4:0];
        ALU_SRA:       return bus32_t'($signed(a) >>> b[4:0]);
        ALU_SLT:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        ALU_SLTU:      return (a < b) ? 32'd1 : 32'd0;
        ALU_PCADDU12I: return pc + b;
        default:       return 32'd0;
    endcase
endfunction

// magnitude divide, then quotient and remainder signs
function automatic bus32_t div_result(aluop_t op, bus32_t a, bus32_t b);
    logic   sgn;
    bus32_t ma;
    bus32_t mb;
    bus32_t q;
    bus32_t r;
    sgn = (op == ALU_DIVW) || (op == ALU_MODW);
    ma = (sgn && a[31]) ? 32'(-a) : a;
    mb = (sgn && b[31]) ? 32'(-b) : b;
    q = (mb == 32'd0) ? 32'hffff_ffff : ma / mb;
    r = (mb == 32'd0) ? ma : ma % mb;
    if (sgn && (a[31] ^ b[31])) begin
        q = -q;
    end
    if (sgn && a[31]) begin
        r = -r;
    end
    return (op == ALU_MODW || op == ALU_MODWU) ? r : q;
endfunction

function automatic logic branch_taken(aluop_t op, bus32_t a, bus32_t b);
    case (op)
        ALU_BEQ:  return a == b;
        ALU_BNE:  return a != b;
        ALU_BLT:  return $signed(a) < $signed(b);
        ALU_BGE:  return $signed(a) >= $signed(b);
        ALU_BLTU: return a < b;
        ALU_BGEU: return a >= b;
        default:  return 1'b1;
    endcase
endfunction

// jump destination when taken; offs26 high part lives in inst[9:0]
function automatic bus32_t branch_dest(aluop_t op, bus32_t pc, bus32_t inst, bus32_t a);
    bus32_t off16;
    bus32_t off26;
    off16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    off26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
    if (op == ALU_JIRL) begin
        return a + off16;
    end
    if (op == ALU_B || op == ALU_BL) begin
        return pc + off26;
    end
    return pc + off16;
endfunction

function automatic logic [3:0] store_lanes(aluop_t op, logic [1:0] off);
    case (op)
        ALU_STB: return 4'b0001 << off;
        ALU_STH: return off[1] ? 4'b1100 : 4'b0011;
        default: return 4'b1111;
    endcase
endfunction

function automatic bus32_t store_word(aluop_t op, bus32_t d);
    case (op)
        ALU_STB: return {4{d[7:0]}};
        ALU_STH: return {2{d[15:0]}};
        default: return d;
    endcase
endfunction

function automatic logic access_misaligned(aluop_t op, logic [1:0] off);
    case (op)
        ALU_LDH, ALU_LDHU, ALU_STH: return off[0];
        ALU_LDW, ALU_STW:           return off != 2'b00;
        default:                    return 1'b0;
    endcase
endfunction

`endif

// File: tb/tb_main_ex.sv
module tb_main_ex;
    timeunit 1ns;
    timeprecision 1ps;
    import ex_pkg::*;

    `include "ex_model.svh"

    localparam bus32_t UNCACHE_LIMIT = 32'h0000_0120;
    // ~32 divides of 34 cycles plus ~200 short cycles, with wide margin
    localparam int MAX_CYCLES = 3000;

    logic                  clk = 1'b0;
    logic                  reset_i;
    logic                  inst_valid_i;
    bus32_t                pc_i;
    bus32_t                inst_i;
    aluop_t                aluop_i;
    alusel_t               alusel_i;
    bus32_t                reg1_i;
    bus32_t                reg2_i;
    logic                  reg_write_en_i;
    logic [REG_ADDR_W-1:0] reg_write_addr_i;
    logic                  pre_taken_i;
    bus32_t                pre_target_i;
    bus64_t                cnt_i;
    logic                  dcache_addr_ok_i;
    logic                  reg_write_en_o;
    logic [REG_ADDR_W-1:0] reg_write_addr_o;
    bus32_t                reg_write_data_o;
    bus32_t                mem_addr_o;
    logic                  ale_o;
    logic                  pause_o;
    logic                  branch_flush_o;
    bus32_t                branch_target_o;
    logic                  dcache_valid_o;
    logic                  dcache_uncache_o;
    logic                  dcache_op_o;
    bus32_t                dcache_addr_o;
    bus32_t                dcache_wdata_o;
    logic [3:0]            dcache_wstrb_o;

    int seed;
    int cycles = 0;

    main_ex #(
        .UNCACHE_PC_LIMIT (UNCACHE_LIMIT)
    ) u_main_ex (
        .clk              (clk),
        .reset_i          (reset_i),
        .inst_valid_i     (inst_valid_i),
        .pc_i             (pc_i),
        .inst_i           (inst_i),
        .aluop_i          (aluop_i),
        .alusel_i         (alusel_i),
        .reg1_i           (reg1_i),
        .reg2_i           (reg2_i),
        .reg_write_en_i   (reg_write_en_i),
        .reg_write_addr_i (reg_write_addr_i),
        .pre_taken_i      (pre_taken_i),
        .pre_target_i     (pre_target_i),
        .cnt_i            (cnt_i),
        .dcache_addr_ok_i (dcache_addr_ok_i),
        .reg_write_en_o   (reg_write_en_o),
        .reg_write_addr_o (reg_write_addr_o),
        .reg_write_data_o (reg_write_data_o),
        .mem_addr_o       (mem_addr_o),
        .ale_o            (ale_o),
        .pause_o          (pause_o),
        .branch_flush_o   (branch_flush_o),
        .branch_target_o  (branch_target_o),
        .dcache_valid_o   (dcache_valid_o),
        .dcache_uncache_o (dcache_uncache_o),
        .dcache_op_o      (dcache_op_o),
        .dcache_addr_o    (dcache_addr_o),
        .dcache_wdata_o   (dcache_wdata_o),
        .dcache_wstrb_o   (dcache_wstrb_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Simulation failed");
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $fatal(1, "run stopped on timeout");
        end
    end

    task automatic check_value(input string name, input bus32_t got, input bus32_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // new instruction 10 ns after the rising edge
    task automatic issue(input aluop_t op, input alusel_t sel, input bus32_t pc,
                         input bus32_t inst, input bus32_t a, input bus32_t b);
        @(posedge clk);
        #10;
        inst_valid_i = 1'b1;
        aluop_i = op;
        alusel_i = sel;
        pc_i = pc;
        inst_i = inst;
        reg1_i = a;
        reg2_i = b;
    endtask

    task automatic exercise_alu();
        aluop_t  ops[12];
        alusel_t sels[12];
        bus32_t  a;
        bus32_t  b;
        bus32_t  pc;
        ops = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL,
                ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PCADDU12I};
        sels = '{ALU_SEL_ARITHMETIC, ALU_SEL_ARITHMETIC, ALU_SEL_LOGIC, ALU_SEL_LOGIC,
                 ALU_SEL_LOGIC, ALU_SEL_LOGIC, ALU_SEL_SHIFT, ALU_SEL_SHIFT,
                 ALU_SEL_SHIFT, ALU_SEL_ARITHMETIC, ALU_SEL_ARITHMETIC, ALU_SEL_ARITHMETIC};
        for (int i = 0; i < 12; i++) begin
            for (int k = 0; k < 4; k++) begin
                a = $random(seed);
                b = $random(seed);
                pc = $random(seed);
                issue(ops[i], sels[i], pc, 32'h0, a, b);
                reg_write_en_i = 1'b1;
                reg_write_addr_i = 5'(i + k);
                @(negedge clk);
                check_value("reg_write_data_o", reg_write_data_o, alu_result(ops[i], pc, a, b));
                check_value("reg_write_en_o", 32'(reg_write_en_o), 32'd1);
                check_value("reg_write_addr_o", 32'(reg_write_addr_o), 32'(5'(i + k)));
            end
        end
        reg_write_en_i = 1'b0;
    endtask

    // waits on pause_o; the done cycle is the first one with pause low
    task automatic divide_once(input aluop_t op, input bus32_t a, input bus32_t b);
        int stalled;
        stalled = 0;
        issue(op, ALU_SEL_DIV, 32'h1c00_0000, 32'h0, a, b);
        @(negedge clk);
        while (pause_o) begin
            stalled++;
            @(negedge clk);
        end
        check_value("divide pause cycles", 32'(stalled), 32'd33);
        check_value("reg_write_data_o", reg_write_data_o, div_result(op, a, b));
    endtask

    task automatic divide_cases();
        aluop_t ops[4];
        bus32_t dvd[8];
        bus32_t dvs[8];
        ops = '{ALU_DIVW, ALU_MODW, ALU_DIVWU, ALU_MODWU};
        for (int i = 0; i < 4; i++) begin
            dvd = '{32'h8000_0000, 32'h1234_5678, 32'hffff_fff9, 32'hffff_fff9,
                    32'h0000_0007, $random(seed), $random(seed), $random(seed)};
            dvs = '{32'hffff_ffff, 32'h0, 32'h0, 32'h2,
                    32'hffff_fffe, $random(seed), $random(seed), {28'h0, 4'($random(seed))}};
            for (int k = 0; k < 8; k++) begin
                divide_once(ops[i], dvd[k], dvs[k]);
            end
        end
    endtask

    task automatic resolve_branches();
        aluop_t ops[9];
        bus32_t a;
        bus32_t b;
        bus32_t pc;
        bus32_t inst;
        bus32_t dest;
        bus32_t seq;
        bus32_t pre_d;
        logic   taken;
        logic   pre_t;
        logic   flush;
        ops = '{ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
                ALU_JIRL, ALU_B, ALU_BL};
        // mode 0 predicted taken, 1 predicted not taken, 2 stale target
        for (int i = 0; i < 9; i++) begin
            for (int mode = 0; mode < 3; mode++) begin
                a = $random(seed);
                b = (mode == 1) ? a : $random(seed);
                pc = $random(seed);
                pc[1:0] = 2'b00;
                inst = $random(seed);
                taken = branch_taken(ops[i], a, b);
                dest = branch_dest(ops[i], pc, inst, a);
                seq = pc + 32'd4;
                pre_t = mode != 1;
                pre_d = (mode == 2) ? (dest ^ 32'h0000_0040) : dest;
                flush = (taken != pre_t) || (taken && (pre_d != dest));
                issue(ops[i], ALU_SEL_JUMP_BRANCH, pc, inst, a, b);
                pre_taken_i = pre_t;
                pre_target_i = pre_d;
                @(negedge clk);
                check_value("branch_flush_o", 32'(branch_flush_o), 32'(flush));
                check_value("branch_target_o", branch_target_o, taken ? dest : seq);
                if (ops[i] == ALU_BL || ops[i] == ALU_JIRL) begin
                    check_value("reg_write_data_o", reg_write_data_o, seq);
                end
            end
        end
        pre_taken_i = 1'b0;
    endtask

    task automatic memory_lanes();
        aluop_t ops[8];
        bus32_t pc;
        bus32_t inst;
        bus32_t si12;
        bus32_t addr;
        bus32_t data;
        logic   bad;
        logic   is_st;
        ops = '{ALU_STB, ALU_STH, ALU_STW, ALU_LDB, ALU_LDBU, ALU_LDH, ALU_LDHU, ALU_LDW};
        dcache_addr_ok_i = 1'b1;
        // region 0 sits below the uncached limit
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 8; i++) begin
                for (int off = 0; off < 4; off++) begin
                    pc = (r == 0) ? 32'h0000_0100 : 32'h1c00_0000 + 32'(i * 64 + off * 4);
                    inst = $random(seed);
                    si12 = {{20{inst[21]}}, inst[21:10]};
                    addr = $random(seed);
                    addr[1:0] = 2'(off);
                    data = $random(seed);
                    bad = access_misaligned(ops[i], addr[1:0]);
                    is_st = ops[i] inside {ALU_STB, ALU_STH, ALU_STW};
                    issue(ops[i], ALU_SEL_LOAD_STORE, pc, inst, addr - si12, data);
                    @(negedge clk);
                    check_value("mem_addr_o", mem_addr_o, addr);
                    check_value("ale_o", 32'(ale_o), 32'(bad));
                    check_value("dcache_valid_o", 32'(dcache_valid_o), 32'(!bad && r == 1));
                    check_value("dcache_uncache_o", 32'(dcache_uncache_o), 32'(!bad && r == 0));
                    check_value("pause_o", 32'(pause_o), 32'd0);
                    check_value("reg_write_data_o", reg_write_data_o, 32'd0);
                    if (!bad) begin
                        check_value("dcache_addr_o", dcache_addr_o, addr);
                        check_value("dcache_op_o", 32'(dcache_op_o), 32'(is_st));
                    end
                    if (!bad && is_st) begin
                        check_value("dcache_wstrb_o", 32'(dcache_wstrb_o),
                                    32'(store_lanes(ops[i], addr[1:0])));
                        check_value("dcache_wdata_o", dcache_wdata_o, store_word(ops[i], data));
                    end
                end
            end
        end
    endtask

    task automatic stall_and_counters();
        int     n;
        bus32_t addr;
        bus32_t lo;
        bus32_t hi;
        for (int t = 0; t < 3; t++) begin
            n = 1 + ($random(seed) & 7);
            addr = $random(seed);
            addr[1:0] = 2'b00;
            issue(ALU_STW, ALU_SEL_LOAD_STORE, 32'h1c00_0400, 32'h0, addr, $random(seed));
            dcache_addr_ok_i = 1'b0;
            repeat (n) begin
                @(negedge clk);
                check_value("pause_o", 32'(pause_o), 32'd1);
                check_value("dcache_valid_o", 32'(dcache_valid_o), 32'd1);
                @(posedge clk);
                #10;
            end
            dcache_addr_ok_i = 1'b1;
            @(negedge clk);
            check_value("pause_o", 32'(pause_o), 32'd0);
            check_value("dcache_valid_o", 32'(dcache_valid_o), 32'd1);
        end
        lo = $random(seed);
        hi = $random(seed);
        cnt_i = {hi, lo};
        issue(ALU_RDCNTVLW, ALU_SEL_COUNTER, 32'h1c00_0000, 32'h0, 32'h0, 32'h0);
        @(negedge clk);
        check_value("reg_write_data_o", reg_write_data_o, lo);
        issue(ALU_RDCNTVHW, ALU_SEL_COUNTER, 32'h1c00_0000, 32'h0, 32'h0, 32'h0);
        @(negedge clk);
        check_value("reg_write_data_o", reg_write_data_o, hi);
        // no valid instruction, so no request, flush or divide
        issue(ALU_STW, ALU_SEL_LOAD_STORE, 32'h1c00_0000, 32'h0, 32'h0, 32'h0);
        inst_valid_i = 1'b0;
        dcache_addr_ok_i = 1'b0;
        @(negedge clk);
        check_value("dcache_valid_o", 32'(dcache_valid_o), 32'd0);
        check_value("dcache_uncache_o", 32'(dcache_uncache_o), 32'd0);
        check_value("pause_o", 32'(pause_o), 32'd0);
        issue(ALU_BEQ, ALU_SEL_JUMP_BRANCH, 32'h1c00_0000, 32'h0, 32'h5, 32'h5);
        inst_valid_i = 1'b0;
        pre_taken_i = 1'b0;
        @(negedge clk);
        check_value("branch_flush_o", 32'(branch_flush_o), 32'd0);
        issue(ALU_DIVW, ALU_SEL_DIV, 32'h1c00_0000, 32'h0, 32'h9, 32'h3);
        inst_valid_i = 1'b0;
        @(negedge clk);
        check_value("pause_o", 32'(pause_o), 32'd0);
        dcache_addr_ok_i = 1'b1;
    endtask

    initial begin
        seed = 32'hba68_5421;
        reset_i = 1'b1;
        inst_valid_i = 1'b0;
        pc_i = 32'h0;
        inst_i = 32'h0;
        aluop_i = ALU_NOP;
        alusel_i = ALU_SEL_NONE;
        reg1_i = 32'h0;
        reg2_i = 32'h0;
        reg_write_en_i = 1'b0;
        reg_write_addr_i = '0;
        pre_taken_i = 1'b0;
        pre_target_i = 32'h0;
        cnt_i = 64'h0;
        dcache_addr_ok_i = 1'b1;
        repeat (5) @(posedge clk);
        #10;
        reset_i = 1'b0;
        @(negedge clk);
        check_value("pause_o", 32'(pause_o), 32'd0);
        check_value("branch_flush_o", 32'(branch_flush_o), 32'd0);
        check_value("dcache_valid_o", 32'(dcache_valid_o), 32'd0);
        check_value("dcache_uncache_o", 32'(dcache_uncache_o), 32'd0);
        exercise_alu();
        divide_cases();
        resolve_branches();
        memory_lanes();
        stall_and_counters();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+tb
verilog/ex_pkg.sv
verilog/regular_alu.sv
verilog/div_alu.sv
verilog/branch_alu.sv
verilog/lsu_agu.sv
verilog/main_ex.sv
tb/tb_main_ex.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = tb_main_ex
FILELIST = vlog.f
PASS_MSG = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP), pass if the output says so"
	@echo "  clean  remove obj_dir"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
